// File: hdl/sifh_pkg.sv
package sifh_pkg;

    // Sample format
    localparam int DATA_W = 8;
    localparam int BIN_W  = 4;                   // Upper sample bits used as bin index
    localparam int BINS   = 1 << BIN_W;

    // Frame geometry
    localparam int PIXEL_NUM         = 4;        // Power of two for the split scan address
    localparam int PIXEL_W           = $clog2(PIXEL_NUM);
    localparam int SAMPLES_PER_PIXEL = 2;
    localparam int SAMPLE_IDX_W      = $clog2(SAMPLES_PER_PIXEL);
    localparam int ACQ_NUM           = 8;
    localparam int ACQ_W             = $clog2(ACQ_NUM);

    // Worst case is every sample of a pixel landing in one bin
    localparam int COUNT_W = $clog2(SAMPLES_PER_PIXEL * ACQ_NUM + 1);

    // Peak search walks every bin of every pixel
    localparam int SCAN_CYCLES = PIXEL_NUM * BINS;
    localparam int SCAN_W      = PIXEL_W + BIN_W;

    typedef logic [DATA_W-1:0]  sample_t;
    typedef logic [BIN_W-1:0]   bin_t;
    typedef logic [COUNT_W-1:0] count_t;
    typedef logic [PIXEL_W-1:0] pixel_t;

    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUILD  = 2'b01,
        SEARCH = 2'b10
    } sifh_state_t;

endpackage

// File: hdl/sample_sequencer.sv
`timescale 1ns/1ps

module sample_sequencer
    import sifh_pkg::*;
(
    input  logic   clk,
    input  logic   res,
    input  logic   wr_en,
    input  logic   scan_done,
    output logic   busy,
    output logic   accept,
    output pixel_t pixel,
    output logic   frame_full
);

    sifh_state_t state;

    logic [SAMPLE_IDX_W-1:0] sample_cnt;
    pixel_t                  pixel_cnt;
    logic [ACQ_W-1:0]        acq_cnt;

    logic last_sample;
    logic last_pixel;
    logic last_acq;
    logic final_sample;

    // Strobes during the search are dropped
    assign accept = wr_en && (state != SEARCH);
    assign busy   = (state != IDLE);
    assign pixel  = pixel_cnt;

    assign last_sample  = (sample_cnt == SAMPLE_IDX_W'(SAMPLES_PER_PIXEL - 1));
    assign last_pixel   = (pixel_cnt == PIXEL_W'(PIXEL_NUM - 1));
    assign last_acq     = (acq_cnt == ACQ_W'(ACQ_NUM - 1));
    assign final_sample = accept && last_sample && last_pixel && last_acq;

    // Sample within pixel, then pixel, then acquisition
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            sample_cnt <= '0;
            pixel_cnt  <= '0;
            acq_cnt    <= '0;
        end else if (scan_done) begin
            sample_cnt <= '0;
            pixel_cnt  <= '0;
            acq_cnt    <= '0;
        end else if (accept) begin
            if (!last_sample) begin
                sample_cnt <= sample_cnt + 1'b1;
            end else begin
                sample_cnt <= '0;
                if (!last_pixel) begin
                    pixel_cnt <= pixel_cnt + 1'b1;
                end else begin
                    pixel_cnt <= '0;
                    if (!last_acq)
                        acq_cnt <= acq_cnt + 1'b1;
                    else
                        acq_cnt <= '0;              // Frame complete
                end
            end
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state      <= IDLE;
            frame_full <= 1'b0;
        end else begin
            frame_full <= final_sample;
            case (state)
                IDLE: begin
                    if (final_sample)
                        state <= SEARCH;
                    else if (accept)
                        state <= BUILD;         // First sample counts too
                end
                BUILD: begin
                    if (final_sample)
                        state <= SEARCH;
                end
                SEARCH: begin
                    if (scan_done)
                        state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: hdl/histogram_ram.sv
`timescale 1ns/1ps

module histogram_ram
    import sifh_pkg::*;
(
    input  logic    clk,
    input  logic    res,
    input  logic    accept,
    input  pixel_t  pixel,
    input  sample_t data,
    input  logic    clear,
    input  pixel_t  rd_pixel,
    input  bin_t    rd_bin,
    output count_t  rd_count
);

    // One counter per bin per pixel
    count_t hist [PIXEL_NUM][BINS];

    bin_t wr_bin;

    assign wr_bin = data[DATA_W-1 -: BIN_W];

    // Read-modify-write in one cycle for back-to-back hits on one bin
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            for (int p = 0; p < PIXEL_NUM; p++) begin
                for (int b = 0; b < BINS; b++) begin
                    hist[p][b] <= '0;
                end
            end
        end else if (clear) begin
            for (int p = 0; p < PIXEL_NUM; p++) begin
                for (int b = 0; b < BINS; b++) begin
                    hist[p][b] <= '0;
                end
            end
        end else if (accept) begin
            hist[pixel][wr_bin] <= hist[pixel][wr_bin] + 1'b1;  // Cannot overflow
        end
    end

    // Combinational read for the peak search
    assign rd_count = hist[rd_pixel][rd_bin];

endmodule

// File: hdl/peak_search.sv
`timescale 1ns/1ps

module peak_search
    import sifh_pkg::*;
(
    input  logic                  clk,
    input  logic                  res,
    input  logic                  frame_full,
    output pixel_t                rd_pixel,
    output bin_t                  rd_bin,
    input  count_t                rd_count,
    output bin_t   [PIXEL_NUM-1:0] result,
    output count_t [PIXEL_NUM-1:0] result_count,
    output logic                  done
);

    logic              scan_active;
    logic [SCAN_W-1:0] scan_cnt;
    logic              last_bin;
    logic              last_scan;

    // Running maximum of the current pixel
    bin_t   best_bin;
    count_t best_count;
    bin_t   cand_bin;
    count_t cand_count;

    // Pairs of finished pixels
    bin_t   [PIXEL_NUM-1:0] stage_bin;
    count_t [PIXEL_NUM-1:0] stage_count;
    bin_t   [PIXEL_NUM-1:0] stage_bin_nxt;
    count_t [PIXEL_NUM-1:0] stage_count_nxt;

    // Pixel in the upper address bits, bin in the lower
    assign rd_pixel  = scan_cnt[SCAN_W-1 -: PIXEL_W];
    assign rd_bin    = scan_cnt[BIN_W-1:0];
    assign last_bin  = (rd_bin == BIN_W'(BINS - 1));
    assign last_scan = (scan_cnt == SCAN_W'(SCAN_CYCLES - 1));

    always_comb begin
        // Strictly greater keeps the lowest index on a tie
        if (rd_bin == '0 || rd_count > best_count) begin
            cand_bin   = rd_bin;
            cand_count = rd_count;
        end else begin
            cand_bin   = best_bin;
            cand_count = best_count;
        end
        stage_bin_nxt             = stage_bin;
        stage_count_nxt           = stage_count;
        stage_bin_nxt[rd_pixel]   = cand_bin;
        stage_count_nxt[rd_pixel] = cand_count;
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            scan_active  <= 1'b0;
            scan_cnt     <= '0;
            done         <= 1'b0;
            result       <= '0;
            result_count <= '0;
        end else begin
            done <= 1'b0;
            if (frame_full) begin               // Setup cycle
                scan_active <= 1'b1;
                scan_cnt    <= '0;
            end else if (scan_active) begin
                scan_cnt <= scan_cnt + 1'b1;
                if (last_scan) begin
                    scan_active  <= 1'b0;
                    result       <= stage_bin_nxt;
                    result_count <= stage_count_nxt;
                    done         <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (scan_active) begin
            best_bin   <= cand_bin;
            best_count <= cand_count;
            if (last_bin) begin
                stage_bin   <= stage_bin_nxt;
                stage_count <= stage_count_nxt;
            end
        end
    end

endmodule

// File: hdl/sifh_top.sv
`timescale 1ns/1ps

module sifh_top
    import sifh_pkg::*;
(
    input  logic                   clk,
    input  logic                   res,
    input  logic                   wr_en,
    input  sample_t                data,
    output logic                   busy,
    output logic                   done,
    output bin_t   [PIXEL_NUM-1:0] result,
    output count_t [PIXEL_NUM-1:0] result_count
);

    logic   accept;
    pixel_t pixel;
    logic   frame_full;
    pixel_t rd_pixel;
    bin_t   rd_bin;
    count_t rd_count;

    sample_sequencer u_sequencer (
        .clk        (clk),
        .res        (res),
        .wr_en      (wr_en),
        .scan_done  (done),
        .busy       (busy),
        .accept     (accept),
        .pixel      (pixel),
        .frame_full (frame_full)
    );

    // done doubles as the histogram clear
    histogram_ram u_histogram (
        .clk      (clk),
        .res      (res),
        .accept   (accept),
        .pixel    (pixel),
        .data     (data),
        .clear    (done),
        .rd_pixel (rd_pixel),
        .rd_bin   (rd_bin),
        .rd_count (rd_count)
    );

    peak_search u_search (
        .clk          (clk),
        .res          (res),
        .frame_full   (frame_full),
        .rd_pixel     (rd_pixel),
        .rd_bin       (rd_bin),
        .rd_count     (rd_count),
        .result       (result),
        .result_count (result_count),
        .done         (done)
    );

endmodule

// File: verification/sifh_properties.sv
`timescale 1ns/1ps

module sifh_properties
    import sifh_pkg::*;
(
    input logic clk,
    input logic res,
    input logic busy,
    input logic done
);

    logic busy_seen;

    // Sticky once the first frame has started
    always_ff @(posedge clk or negedge res) begin
        if (!res)
            busy_seen <= 1'b0;
        else if (busy)
            busy_seen <= 1'b1;
    end

    done_single_cycle: assert property (
        @(posedge clk) disable iff (!res) done |=> !done
    ) else $error("done stayed high for more than one cycle");

    busy_before_done: assert property (
        @(posedge clk) disable iff (!res) done |-> $past(busy)
    ) else $error("busy was low in the cycle before done");

    done_needs_busy: assert property (
        @(posedge clk) disable iff (!res) done |-> busy_seen
    ) else $error("done rose although busy had never been high");

endmodule

bind sifh_top sifh_properties u_properties (
    .clk  (clk),
    .res  (res),
    .busy (busy),
    .done (done)
);

// File: verification/sifh_tb.sv
`timescale 1ns/1ps

module sifh_tb
    import sifh_pkg::*;
();

    localparam int FRAME_SAMPLES  = SAMPLES_PER_PIXEL * PIXEL_NUM * ACQ_NUM;
    localparam int NUM_FRAMES     = 6;
    localparam int MAX_GAP        = 3;
    localparam int TIMEOUT_MARGIN = 200;
    localparam int TIMEOUT_CYCLES =
        NUM_FRAMES * (FRAME_SAMPLES * (MAX_GAP + 1) + SCAN_CYCLES + 2) + TIMEOUT_MARGIN;

    localparam int MODE_UNIFORM = 0;
    localparam int MODE_CONC    = 1;
    localparam int MODE_TIE     = 2;

    logic                   clk;
    logic                   res;
    logic                   wr_en;
    sample_t                data;
    logic                   busy;
    logic                   done;
    bin_t   [PIXEL_NUM-1:0] result;
    count_t [PIXEL_NUM-1:0] result_count;

    // Reference model state
    sample_t frame_data [FRAME_SAMPLES];
    int      model_hist [PIXEL_NUM][BINS];
    bin_t    exp_bin    [PIXEL_NUM];
    count_t  exp_count  [PIXEL_NUM];
    bin_t    conc_bin   [PIXEL_NUM];
    bin_t    tie_lo     [PIXEL_NUM];
    bin_t    tie_hi     [PIXEL_NUM];

    int error_cnt;
    int errs_before;
    int pass_cnt;
    int fail_cnt;
    int cycle_cnt;

    sifh_top dut (
        .clk          (clk),
        .res          (res),
        .wr_en        (wr_en),
        .data         (data),
        .busy         (busy),
        .done         (done),
        .result       (result),
        .result_count (result_count)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_bin(input string name, input bin_t actual, input bin_t expected);
        if (actual !== expected) begin
            error_cnt++;
            $display("mismatch at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
        end
    endtask

    task automatic check_count(input string name, input count_t actual, input count_t expected);
        if (actual !== expected) begin
            error_cnt++;
            $display("mismatch at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            error_cnt++;
            $display("mismatch at %0t: %s is %b, expected %b", $time, name, actual, expected);
        end
    endtask

    task automatic begin_test();
        errs_before = error_cnt;
    endtask

    task automatic report_test(input string name);
        if (error_cnt == errs_before) begin
            pass_cnt++;
            $display("test %s: ok", name);
        end else begin
            fail_cnt++;
            $display("test %s: %0d errors", name, error_cnt - errs_before);
        end
    endtask

    // Samples in arrival order; pixel and acquisition follow from the index
    task automatic build_frame(input int mode);
        int p;
        int k;
        for (int q = 0; q < PIXEL_NUM; q++) begin
            conc_bin[q] = bin_t'($urandom);
            tie_lo[q]   = bin_t'($urandom_range(BINS - 2, 0));
            tie_hi[q]   = bin_t'($urandom_range(int'(tie_lo[q]) + 1, BINS - 1));
        end
        for (int i = 0; i < FRAME_SAMPLES; i++) begin
            p = (i / SAMPLES_PER_PIXEL) % PIXEL_NUM;
            k = (i / (SAMPLES_PER_PIXEL * PIXEL_NUM)) * SAMPLES_PER_PIXEL
                + i % SAMPLES_PER_PIXEL;
            frame_data[i] = sample_t'($urandom);
            case (mode)
                MODE_CONC: frame_data[i][DATA_W-1 -: BIN_W] = conc_bin[p];
                MODE_TIE: begin
                    // Higher bin fills first and ends level with the lower
                    if (k % 2 == 0)
                        frame_data[i][DATA_W-1 -: BIN_W] = tie_hi[p];
                    else
                        frame_data[i][DATA_W-1 -: BIN_W] = tie_lo[p];
                end
                default: ;
            endcase
        end
    endtask

    task automatic build_model();
        int p;
        int b;
        int best_c;
        for (int q = 0; q < PIXEL_NUM; q++) begin
            for (int c = 0; c < BINS; c++)
                model_hist[q][c] = 0;
        end
        for (int i = 0; i < FRAME_SAMPLES; i++) begin
            p = (i / SAMPLES_PER_PIXEL) % PIXEL_NUM;
            b = int'(frame_data[i][DATA_W-1 -: BIN_W]);
            model_hist[p][b]++;
        end
        for (int q = 0; q < PIXEL_NUM; q++) begin
            best_c     = model_hist[q][0];
            exp_bin[q] = '0;
            for (int c = 1; c < BINS; c++) begin
                if (model_hist[q][c] > best_c) begin    // Lowest index keeps a tie
                    best_c     = model_hist[q][c];
                    exp_bin[q] = bin_t'(c);
                end
            end
            exp_count[q] = count_t'(best_c);
        end
    endtask

    task automatic run_frame(input int mode, input int max_gap, input bit busy_strobes);
        int gap;
        int lat;
        build_frame(mode);
        build_model();
        for (int i = 0; i < FRAME_SAMPLES; i++) begin
            gap = (max_gap > 0) ? int'($urandom_range(max_gap, 0)) : 0;
            repeat (gap) begin
                @(negedge clk);
                wr_en = 1'b0;
                data  = sample_t'($urandom);
            end
            @(negedge clk);
            wr_en = 1'b1;
            data  = frame_data[i];
        end
        @(negedge clk);                 // Final sample taken at the edge just passed
        lat = 0;
        while (!done) begin
            if (busy_strobes && busy) begin
                wr_en = 1'b1;           // Must be dropped by the DUT
                data  = sample_t'($urandom);
            end else begin
                wr_en = 1'b0;
            end
            @(negedge clk);
            lat++;
        end
        wr_en = 1'b0;
        if (lat != SCAN_CYCLES + 1) begin
            error_cnt++;
            $display("done came %0d cycles after the final sample instead of %0d",
                     lat, SCAN_CYCLES + 1);
        end
        check_bit("busy", busy, 1'b1);
        for (int p = 0; p < PIXEL_NUM; p++) begin
            check_bin($sformatf("result[%0d]", p), result[pixel_t'(p)], exp_bin[p]);
            check_count($sformatf("result_count[%0d]", p), result_count[pixel_t'(p)],
                        exp_count[p]);
        end
        @(negedge clk);
        check_bit("done", done, 1'b0);  // Single-cycle pulse
        check_bit("busy", busy, 1'b0);
    endtask

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h6739));
        res       = 1'b0;
        wr_en     = 1'b0;
        data      = '0;
        error_cnt = 0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        repeat (10) @(negedge clk);
        res = 1'b1;

        begin_test();
        @(negedge clk);
        check_bit("busy", busy, 1'b0);
        check_bit("done", done, 1'b0);
        for (int p = 0; p < PIXEL_NUM; p++) begin
            check_bin($sformatf("result[%0d]", p), result[pixel_t'(p)], '0);
            check_count($sformatf("result_count[%0d]", p), result_count[pixel_t'(p)], '0);
        end
        report_test("reset values");

        begin_test();
        run_frame(MODE_UNIFORM, 0, 1'b0);
        report_test("random frame, continuous strobes");

        begin_test();
        run_frame(MODE_UNIFORM, MAX_GAP, 1'b1);
        report_test("random gaps, strobes during search");

        begin_test();
        run_frame(MODE_UNIFORM, 0, 1'b0);
        run_frame(MODE_UNIFORM, 1, 1'b0);   // Starts from a cleared histogram
        report_test("back-to-back frames");

        begin_test();
        run_frame(MODE_CONC, 0, 1'b0);
        for (int p = 0; p < PIXEL_NUM; p++) begin
            check_count($sformatf("result_count[%0d]", p), result_count[pixel_t'(p)],
                        count_t'(SAMPLES_PER_PIXEL * ACQ_NUM));
        end
        report_test("concentrated bins");

        begin_test();
        run_frame(MODE_TIE, 0, 1'b0);
        for (int p = 0; p < PIXEL_NUM; p++)
            check_bin($sformatf("result[%0d]", p), result[pixel_t'(p)], tie_lo[p]);
        report_test("ties pick the lower bin");

        $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 pass_cnt + fail_cnt, pass_cnt, fail_cnt, error_cnt);
        if (error_cnt == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// File: vlog.f
hdl/sifh_pkg.sv
hdl/sample_sequencer.sv
hdl/histogram_ram.sv
hdl/peak_search.sv
hdl/sifh_top.sv
verification/sifh_properties.sv
verification/sifh_tb.sv

// File: Makefile
# Verilator flow for the histogram peak finder

VERILATOR ?= verilator
TOP       ?= sifh_tb
RTL_TOP   ?= sifh_top
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Result: PASSED

RTL_SRCS ?= hdl/sifh_pkg.sv \
            hdl/sample_sequencer.sv \
            hdl/histogram_ram.sv \
            hdl/peak_search.sv \
            hdl/sifh_top.sv

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(TOP)

sim: build
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
